//--- source/div_pkg.sv
// Divider and HI/LO definitions

package div_pkg;

    // operand width
    localparam int DATA_W = 32;

    // iteration counter, counts up to DIV_ITER
    localparam int CNT_W = 6;

    // one quotient bit per iteration
    localparam int DIV_ITER = 32;

    // operation presented by the upstream stage
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_DIV  = 3'd1,
        OP_DIVU = 3'd2,
        OP_MTHI = 3'd3,
        OP_MTLO = 3'd4
    } op_e;

    // serial divider states
    typedef enum logic [1:0] {
        DIV_FREE    = 2'b00,
        DIV_BY_ZERO = 2'b01,
        DIV_ON      = 2'b10,
        DIV_END     = 2'b11
    } div_state_e;

endpackage

//--- source/div_if.sv
// Divider request and result bundle
`timescale 1ns/1ps

interface div_if;

    logic                          signed_div;
    logic                          start;
    logic                          annul;
    logic [div_pkg::DATA_W-1:0]    opdata1;
    logic [div_pkg::DATA_W-1:0]    opdata2;
    // remainder in the upper half, quotient in the lower half
    logic [2*div_pkg::DATA_W-1:0]  result;
    logic                          ready;

    modport ctrl (
        output signed_div,
        output start,
        output annul,
        output opdata1,
        output opdata2,
        input  result,
        input  ready
    );

    modport div (
        input  signed_div,
        input  start,
        input  annul,
        input  opdata1,
        input  opdata2,
        output result,
        output ready
    );

endinterface

//--- source/div_unit.sv
// Serial restoring divider
`timescale 1ns/1ps

module div_unit (
    input  logic clk,
    input  logic rst_i,
    div_if.div   dif
);

    localparam int W = div_pkg::DATA_W;

    div_pkg::div_state_e      state;
    logic [div_pkg::CNT_W-1:0] cnt;
    // remainder in [2W:W+1], quotient bits shift in at [W-1:0]
    logic [2*W:0]             dividend;
    logic [W-1:0]             divisor;
    logic                     sign1;
    logic                     sign2;
    logic [W:0]               div_temp;
    logic [W-1:0]             mag1;
    logic [W-1:0]             mag2;
    logic                     neg1;
    logic                     neg2;

    // operand signs only count for signed division
    assign neg1 = dif.signed_div && dif.opdata1[W-1];
    assign neg2 = dif.signed_div && dif.opdata2[W-1];
    assign mag1 = neg1 ? -dif.opdata1 : dif.opdata1;
    assign mag2 = neg2 ? -dif.opdata2 : dif.opdata2;

    // trial subtraction, top bit set means divisor did not fit
    assign div_temp = {1'b0, dividend[2*W-1:W]} - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state      <= div_pkg::DIV_FREE;
            cnt        <= '0;
            sign1      <= 1'b0;
            sign2      <= 1'b0;
            dif.ready  <= 1'b0;
            dif.result <= '0;
        end else begin
            case (state)
                div_pkg::DIV_FREE: begin
                    if (dif.start && !dif.annul) begin
                        if (dif.opdata2 == '0) begin
                            state <= div_pkg::DIV_BY_ZERO;
                        end else begin
                            state    <= div_pkg::DIV_ON;
                            cnt      <= '0;
                            sign1    <= neg1;
                            sign2    <= neg2;
                            dividend <= {{W{1'b0}}, mag1, 1'b0};
                            divisor  <= mag2;
                        end
                    end else begin
                        dif.ready  <= 1'b0;
                        dif.result <= '0;
                    end
                end

                div_pkg::DIV_BY_ZERO: begin
                    // result of x/0 is zero in both halves
                    dividend <= '0;
                    if (dif.annul) begin
                        state <= div_pkg::DIV_FREE;
                    end else begin
                        state <= div_pkg::DIV_END;
                    end
                end

                div_pkg::DIV_ON: begin
                    if (dif.annul) begin
                        state <= div_pkg::DIV_FREE;
                        cnt   <= '0;
                    end else if (cnt != div_pkg::CNT_W'(div_pkg::DIV_ITER)) begin
                        if (div_temp[W]) begin
                            dividend <= {dividend[2*W-1:0], 1'b0};
                        end else begin
                            dividend <= {div_temp[W-1:0], dividend[W-1:0], 1'b1};
                        end
                        cnt <= cnt + 1'b1;
                    end else begin
                        // sign fix
                        if (sign1 ^ sign2) begin
                            dividend[W-1:0] <= -dividend[W-1:0];
                        end
                        // remainder follows the dividend
                        if (sign1) begin
                            dividend[2*W:W+1] <= -dividend[2*W:W+1];
                        end
                        state <= div_pkg::DIV_END;
                        cnt   <= '0;
                    end
                end

                div_pkg::DIV_END: begin
                    if (!dif.start) begin
                        state      <= div_pkg::DIV_FREE;
                        dif.ready  <= 1'b0;
                        dif.result <= '0;
                    end else begin
                        dif.result <= {dividend[2*W:W+1], dividend[W-1:0]};
                        dif.ready  <= 1'b1;
                    end
                end

                default: begin
                    state <= div_pkg::DIV_FREE;
                end
            endcase
        end
    end

    // result only offered while holding in the end state
    a_ready_in_end: assert property (
        @(posedge clk) disable iff (rst_i)
        dif.ready |-> state == div_pkg::DIV_END
    );

    a_cnt_range: assert property (
        @(posedge clk) disable iff (rst_i)
        cnt <= div_pkg::CNT_W'(div_pkg::DIV_ITER)
    );

endmodule

//--- source/hilo_ctrl.sv
// HI/LO control and divider sequencing
`timescale 1ns/1ps

module hilo_ctrl (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         op_valid_i,
    input  div_pkg::op_e                 op_code_i,
    input  logic [div_pkg::DATA_W-1:0]   rs_data_i,
    input  logic [div_pkg::DATA_W-1:0]   rt_data_i,
    input  logic                         flush_i,
    output logic                         stall_o,
    output logic [div_pkg::DATA_W-1:0]   hi_o,
    output logic [div_pkg::DATA_W-1:0]   lo_o,
    div_if.ctrl                          dif
);

    localparam int W = div_pkg::DATA_W;

    logic is_div;
    logic is_mthi;
    logic is_mtlo;
    logic release_q;
    logic div_ready;
    logic div_done;

    // decode
    assign is_div  = op_valid_i &&
                     (op_code_i == div_pkg::OP_DIV || op_code_i == div_pkg::OP_DIVU);
    assign is_mthi = op_valid_i && op_code_i == div_pkg::OP_MTHI && !flush_i;
    assign is_mtlo = op_valid_i && op_code_i == div_pkg::OP_MTLO && !flush_i;

    // ready seen during the release cycle belongs to the previous division
    assign div_ready = dif.ready && !release_q;
    assign div_done  = is_div && div_ready && !flush_i;

    assign stall_o = is_div && !div_ready && !flush_i;

    // divider request held until ready
    assign dif.start      = is_div && !release_q && !flush_i;
    assign dif.signed_div = op_code_i == div_pkg::OP_DIV;
    assign dif.opdata1    = rs_data_i;
    assign dif.opdata2    = rt_data_i;
    assign dif.annul      = flush_i;

    // drop start for one cycle after each completed division
    always_ff @(posedge clk) begin
        if (rst_i) begin
            release_q <= 1'b0;
        end else begin
            release_q <= div_done;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else begin
            if (div_done) begin
                // remainder to HI and quotient to LO
                hi_o <= dif.result[2*W-1:W];
                lo_o <= dif.result[W-1:0];
            end else if (is_mthi) begin
                hi_o <= rs_data_i;
            end else if (is_mtlo) begin
                lo_o <= rs_data_i;
            end
        end
    end

    // upstream keeps the operation presented while stalled
    a_stall_needs_op: assert property (
        @(posedge clk) disable iff (rst_i)
        stall_o |=> op_valid_i
    );

endmodule

//--- source/div_top.sv
// Divide and HI/LO subsystem top
`timescale 1ns/1ps

module div_top (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        op_valid_i,
    input  logic [2:0]  op_code_i,
    input  logic [31:0] rs_data_i,
    input  logic [31:0] rt_data_i,
    input  logic        flush_i,
    output logic        stall_o,
    output logic [31:0] hi_o,
    output logic [31:0] lo_o
);

    // controller to divider
    div_if dif ();

    hilo_ctrl i_hilo_ctrl (
        .clk        (clk),
        .rst_i      (rst_i),
        .op_valid_i (op_valid_i),
        .op_code_i  (div_pkg::op_e'(op_code_i)),
        .rs_data_i  (rs_data_i),
        .rt_data_i  (rt_data_i),
        .flush_i    (flush_i),
        .stall_o    (stall_o),
        .hi_o       (hi_o),
        .lo_o       (lo_o),
        .dif        (dif.ctrl)
    );

    div_unit i_div_unit (
        .clk   (clk),
        .rst_i (rst_i),
        .dif   (dif.div)
    );

endmodule

//--- test/div_tb_clock.sv
// Testbench clock source
`timescale 1ns/1ps

module div_tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- test/div_tb.sv
// Divide and HI/LO testbench
`timescale 1ns/1ps

module div_tb;

    localparam int MAX_CYCLES = 6000;

    logic        clk;
    logic        rst_i;
    logic        op_valid_i;
    logic [2:0]  op_code_i;
    logic [31:0] rs_data_i;
    logic [31:0] rt_data_i;
    logic        flush_i;
    logic        stall_o;
    logic [31:0] hi_o;
    logic [31:0] lo_o;

    integer      seed = 10;
    integer      err_count = 0;
    integer      test_errs = 0;
    integer      tests_ok = 0;
    integer      tests_bad = 0;
    integer      cycles = 0;
    logic [31:0] exp_hi = '0;
    logic [31:0] exp_lo = '0;
    logic        check_pending = 1'b0;

    div_tb_clock #(.PERIOD_NS(20)) i_clock (.clk_o(clk));

    div_top i_div_top (
        .clk        (clk),
        .rst_i      (rst_i),
        .op_valid_i (op_valid_i),
        .op_code_i  (op_code_i),
        .rs_data_i  (rs_data_i),
        .rt_data_i  (rt_data_i),
        .flush_i    (flush_i),
        .stall_o    (stall_o),
        .hi_o       (hi_o),
        .lo_o       (lo_o)
    );

    // expected {HI, LO} with the quotient truncated toward zero
    function automatic logic [63:0] div_ref(input logic [31:0] a, input logic [31:0] b,
                                            input logic sgn);
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] r;
        if (b == 32'd0) begin
            return 64'd0;
        end
        ma = (sgn && a[31]) ? -a : a;
        mb = (sgn && b[31]) ? -b : b;
        q = ma / mb;
        r = ma % mb;
        if (sgn && (a[31] ^ b[31])) begin
            q = -q;
        end
        // remainder carries the dividend sign
        if (sgn && a[31]) begin
            r = -r;
        end
        return {r, q};
    endfunction

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, act, exp);
            err_count = err_count + 1;
        end
    endtask

    // one compare after each write edge
    always @(negedge clk) begin
        if (check_pending) begin
            check_val("hi_o", hi_o, exp_hi);
            check_val("lo_o", lo_o, exp_lo);
            check_pending = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a division never completed", cycles);
            $display("test failed");
            $finish;
        end
    end

    // starts just after a rising edge and returns at the write edge
    task automatic run_div(input logic [31:0] a, input logic [31:0] b, input logic sgn,
                           input integer exp_stalls);
        logic [63:0] res;
        integer      stalls;
        stalls = 0;
        op_valid_i <= 1'b1;
        op_code_i  <= sgn ? div_pkg::OP_DIV : div_pkg::OP_DIVU;
        rs_data_i  <= a;
        rt_data_i  <= b;
        @(negedge clk);
        while (stall_o) begin
            stalls = stalls + 1;
            @(negedge clk);
        end
        check_val("stall_cycles", stalls, exp_stalls);
        @(posedge clk);
        res = div_ref(a, b, sgn);
        exp_hi = res[63:32];
        exp_lo = res[31:0];
        check_pending = 1'b1;
        op_valid_i <= 1'b0;
    endtask

    task automatic move_reg(input logic to_hi, input logic [31:0] d);
        op_valid_i <= 1'b1;
        op_code_i  <= to_hi ? div_pkg::OP_MTHI : div_pkg::OP_MTLO;
        rs_data_i  <= d;
        @(negedge clk);
        check_val("stall_o", stall_o, 32'd0);
        @(posedge clk);
        if (to_hi) begin
            exp_hi = d;
        end else begin
            exp_lo = d;
        end
        check_pending = 1'b1;
        op_valid_i <= 1'b0;
    endtask

    function automatic logic [31:0] rand_nonzero();
        logic [31:0] v;
        v = $random(seed);
        return (v == 32'd0) ? 32'd1 : v;
    endfunction

    task automatic finish_test(input string name);
        @(posedge clk);
        if (err_count == test_errs) begin
            $display("%s: ok", name);
            tests_ok = tests_ok + 1;
        end else begin
            $display("%s: %0d errors", name, err_count - test_errs);
            tests_bad = tests_bad + 1;
        end
        test_errs = err_count;
    endtask

    initial begin
        integer      i;
        integer      k;
        logic [31:0] va;
        logic [31:0] vb;
        rst_i      = 1'b1;
        op_valid_i = 1'b0;
        op_code_i  = div_pkg::OP_NONE;
        rs_data_i  = '0;
        rt_data_i  = '0;
        flush_i    = 1'b0;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);

        for (i = 0; i < 16; i++) begin
            va = $random(seed);
            run_div(va, rand_nonzero(), 1'b0, 35);
            @(posedge clk);
        end
        finish_test("divu random");

        run_div(32'd100, 32'd7, 1'b1, 35);
        @(posedge clk);
        run_div(-32'd100, 32'd7, 1'b1, 35);
        @(posedge clk);
        run_div(32'd100, -32'd7, 1'b1, 35);
        @(posedge clk);
        run_div(-32'd100, -32'd7, 1'b1, 35);
        @(posedge clk);
        for (i = 0; i < 16; i++) begin
            va = $random(seed);
            run_div(va, rand_nonzero(), 1'b1, 35);
            @(posedge clk);
        end
        run_div(32'h8000_0000, 32'hffff_ffff, 1'b1, 35);
        finish_test("div signed");

        // nonzero HI and LO before each zero write
        run_div(32'd100, 32'd7, 1'b0, 35);
        @(posedge clk);
        run_div($random(seed), 32'd0, 1'b1, 3);
        @(posedge clk);
        run_div(32'd100, 32'd7, 1'b0, 35);
        @(posedge clk);
        run_div($random(seed), 32'd0, 1'b0, 3);
        finish_test("divide by zero");

        move_reg(1'b1, $random(seed));
        @(posedge clk);
        move_reg(1'b0, $random(seed));
        finish_test("mthi mtlo");

        // flush lands while the divider iterates
        k = 2 + ($unsigned($random(seed)) % 30);
        op_valid_i <= 1'b1;
        op_code_i  <= div_pkg::OP_DIV;
        rs_data_i  <= $random(seed);
        rt_data_i  <= rand_nonzero();
        repeat (k) @(posedge clk);
        flush_i <= 1'b1;
        @(negedge clk);
        if (stall_o) begin
            $display("flush in cycle %0d did not drop stall_o", k + 1);
            err_count = err_count + 1;
        end
        @(posedge clk);
        flush_i    <= 1'b0;
        op_valid_i <= 1'b0;
        check_pending = 1'b1;
        @(posedge clk);
        va = $random(seed);
        run_div(va, rand_nonzero(), 1'b1, 35);
        finish_test("flush");

        va = $random(seed);
        run_div(va, rand_nonzero(), 1'b0, 35);
        vb = $random(seed);
        run_div(vb, rand_nonzero(), 1'b1, 36);
        finish_test("back to back");

        $display("summary: %0d ok, %0d with errors, %0d mismatches",
                 tests_ok, tests_bad, err_count);
        if (tests_bad == 0 && err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/div_pkg.sv
source/div_if.sv
source/div_unit.sv
source/hilo_ctrl.sv
source/div_top.sv
test/div_tb_clock.sv
test/div_tb.sv

//--- Makefile
# Verilator build and run of the divider testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
